/* Makefile */
# Verilator build, run and lint for the read master

VERILATOR ?= verilator
TOP       ?= tb_rm_top
RTL_TOP   ?= rm_read_master
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/100ps
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+logic
logic/rm_pkg.sv
logic/rm_request_setup.sv
logic/rm_addr_issue.sv
logic/rm_beat_fifo.sv
logic/rm_completion.sv
logic/rm_read_master.sv
dv/rm_mem_model.sv
dv/tb_rm_top.sv

/* dv/rm_mem_model.sv */
// Memory slave model for the read master testbench
// Answers bursts with address-derived data and random ready and valid gaps

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_mem_model
  import rm_pkg::*;
(
  input  logic     aclk,
  input  logic     areset,
  input  logic     ar_valid,
  output logic     ar_ready,
  input  rm_ar_t   ar,
  output logic     r_valid,
  input  logic     r_ready,
  output rm_beat_t r
);

  localparam int AW = `RM_ADDR_WIDTH;
  localparam int DW = `RM_DATA_WIDTH;
  localparam int DB = `RM_DATA_BYTES;

  integer   seed       = 32'h65a31f0f;
  // Accepted bursts waiting for their data
  rm_ar_t   pend_q[$];
  // Index of the beat shown next in the head burst
  int       beat_idx   = 0;
  logic     ar_ready_q = 1'b0;
  logic     r_valid_q  = 1'b0;
  rm_beat_t r_q        = '0;

  assign ar_ready = ar_ready_q;
  assign r_valid  = r_valid_q;
  assign r        = r_q;

  always @(posedge aclk) begin
    if (areset) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      beat_idx = 0;
      pend_q.delete();
    end else begin
      // Address ready about three cycles in four
      ar_ready_q <= ($random(seed) & 3) != 0;
      if (ar_valid && ar_ready_q) begin
        pend_q.push_back(ar);
      end
      // Step through the head burst, drop it after its last beat
      if (r_valid_q && r_ready) begin
        if (r_q.last) begin
          void'(pend_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      // A shown beat holds until taken
      if (!r_valid_q || r_ready) begin
        if (pend_q.size() != 0 && (($random(seed) & 3) != 0)) begin
          r_valid_q <= 1'b1;
          r_q.data  <= DW'(pend_q[0].addr + AW'(beat_idx * DB));
          r_q.last  <= (beat_idx == int'(pend_q[0].len));
        end else begin
          r_valid_q <= 1'b0;
        end
      end
    end
  end

endmodule : rm_mem_model

/* dv/tb_rm_top.sv */
// Testbench for the read master
// Runs a fixed list of transfers against the memory model and checks every channel

`timescale 1ns/100ps
`include "rm_cfg.svh"

module tb_rm_top
  import rm_pkg::*;
();

  localparam int AW     = `RM_ADDR_WIDTH;
  localparam int DW     = `RM_DATA_WIDTH;
  localparam int SZW    = `RM_SIZE_WIDTH;
  localparam int DB     = `RM_DATA_BYTES;
  localparam int BB     = `RM_BURST_BYTES;
  localparam int BEATS  = `RM_BURST_BEATS;
  localparam int MAXO   = `RM_MAX_OUTSTANDING;
  localparam int NTESTS = 8;

  logic           aclk            = 1'b0;
  logic           areset          = 1'b1;
  logic           ctrl_start      = 1'b0;
  logic [AW-1:0]  ctrl_addr       = '0;
  logic [SZW-1:0] ctrl_size_bytes = '0;
  logic           s_ready         = 1'b0;
  logic           ctrl_done;
  logic           ar_valid;
  logic           ar_ready;
  logic           r_valid;
  logic           r_ready;
  logic           s_valid;
  rm_ar_t         ar;
  rm_beat_t       r;
  rm_beat_t       s_beat;

  // Stream mode per test is 0 always ready, 1 random or 2 long low stretches
  logic [AW-1:0] test_addr [NTESTS] = '{32'h0000_1000, 32'h0000_2000, 32'h0000_3047,
                                        32'h0001_0000, 32'h0000_5004, 32'h0000_6000,
                                        32'h0000_7010, 32'h0000_8000};
  int test_size [NTESTS] = '{100, 128, 200, 2560, 300, 4, 65, 1024};
  int test_mode [NTESTS] = '{0, 0, 1, 2, 1, 0, 0, 1};

  rm_beat_t    exp_q[$];
  rm_ar_t      exp_ar_q[$];
  int          errors      = 0;
  int          mode        = 0;
  int          done_cnt    = 0;
  int          r_last_cnt  = 0;
  int          r_last_base = 0;
  int          exp_bursts  = 0;
  int          ar_cnt      = 0;
  int          s_last_cnt  = 0;
  logic        held        = 1'b0;
  rm_beat_t    held_beat   = '0;
  logic [31:0] cyc         = '0;
  integer      sr_seed     = 32'h65a31f0f;

  always #50 aclk = ~aclk;

  rm_read_master DUT (
    .aclk            (aclk),
    .areset          (areset),
    .ctrl_start      (ctrl_start),
    .ctrl_addr       (ctrl_addr),
    .ctrl_size_bytes (ctrl_size_bytes),
    .ctrl_done       (ctrl_done),
    .ar_valid        (ar_valid),
    .ar_ready        (ar_ready),
    .ar              (ar),
    .r_valid         (r_valid),
    .r_ready         (r_ready),
    .r               (r),
    .s_valid         (s_valid),
    .s_ready         (s_ready),
    .s_beat          (s_beat)
  );

  rm_mem_model u_mem (
    .aclk     (aclk),
    .areset   (areset),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Start address aligned down to a full burst
  function automatic logic [AW-1:0] ref_base(logic [AW-1:0] addr);
    return addr - (addr % AW'(BB));
  endfunction

  // Byte count rounded up to whole beats
  function automatic int ref_beats(int size);
    return (size + DB - 1) / DB;
  endfunction

  // Beat i carries its own byte address
  function automatic rm_beat_t ref_beat(logic [AW-1:0] addr, int size, int i);
    rm_beat_t b;
    b.data = DW'(ref_base(addr) + AW'(i * DB));
    b.last = ((i % BEATS) == BEATS - 1) || (i == ref_beats(size) - 1);
    return b;
  endfunction

  // Burst k, full length except the final one
  function automatic rm_ar_t ref_ar(logic [AW-1:0] addr, int size, int k);
    rm_ar_t a;
    int     n;
    n      = ref_beats(size);
    a.addr = ref_base(addr) + AW'(k * BB);
    a.len  = (k == (n - 1) / BEATS) ? 8'((n - 1) % BEATS) : 8'(BEATS - 1);
    return a;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_beat(string name, rm_beat_t got, rm_beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h last %b, expected %h last %b",
               $time, name, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_ar(rm_ar_t got, rm_ar_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: ar got addr %h len %0d, expected addr %h len %0d",
               $time, got.addr, got.len, exp.addr, exp.len);
    end
  endtask

  task automatic check_done_count(integer got, integer exp);
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: ctrl_done pulses got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Stream sink and monitor
  ////////////////////////////////////////

  always @(posedge aclk) begin
    cyc <= cyc + 1'b1;
    case (mode)
      1:       s_ready <= ($random(sr_seed) & 1) != 0;
      // Bit 5 gives 32 cycles low, then 32 high
      2:       s_ready <= cyc[5];
      default: s_ready <= 1'b1;
    endcase
  end

  always @(posedge aclk) begin
    if (!areset) begin
      // A stalled beat must still be there, unchanged
      if (held) begin
        if (!s_valid) begin
          errors++;
          $display("Error at %0t: s_valid dropped before the stream took the beat", $time);
        end else begin
          check_beat("s_beat held", s_beat, held_beat);
        end
      end
      held      = s_valid && !s_ready;
      held_beat = s_beat;
      if (s_valid && s_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: a stream beat arrived when none was expected", $time);
        end else begin
          check_beat("s_beat", s_beat, exp_q.pop_front());
        end
        if (s_beat.last) begin
          s_last_cnt++;
        end
      end
      if (ar_valid && ar_ready) begin
        if (exp_ar_q.size() == 0) begin
          errors++;
          $display("Error at %0t: a burst address was issued when none was expected", $time);
        end else begin
          check_ar(ar, exp_ar_q.pop_front());
        end
        ar_cnt++;
      end
      // Bursts in flight count from address accept to stream last
      if (ar_cnt - s_last_cnt > MAXO) begin
        errors++;
        $display("Error at %0t: %0d bursts in flight, limit is %0d",
                 $time, ar_cnt - s_last_cnt, MAXO);
      end
      if (ctrl_done) begin
        done_cnt++;
        if (r_last_cnt - r_last_base != exp_bursts) begin
          errors++;
          $display("Error at %0t: ctrl_done came before the final last beat on the read bus",
                   $time);
        end
      end
      // The read data channel never stalls
      if (r_valid) begin
        check_level("r_ready", r_ready, 1'b1);
      end
      if (r_valid && r_ready && r.last) begin
        r_last_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic run_test(int idx);
    int base_err;
    int base_done;
    int n;
    base_err    = errors;
    base_done   = done_cnt;
    n           = ref_beats(test_size[idx]);
    r_last_base = r_last_cnt;
    exp_bursts  = (n + BEATS - 1) / BEATS;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(ref_beat(test_addr[idx], test_size[idx], i));
    end
    for (int k = 0; k < exp_bursts; k++) begin
      exp_ar_q.push_back(ref_ar(test_addr[idx], test_size[idx], k));
    end
    mode <= test_mode[idx];
    @(posedge aclk);
    ctrl_start      <= 1'b1;
    ctrl_addr       <= test_addr[idx];
    ctrl_size_bytes <= SZW'(test_size[idx]);
    @(posedge aclk);
    ctrl_start <= 1'b0;
    // Done and a drained stream both end the transfer
    while (done_cnt == base_done || exp_q.size() != 0) begin
      @(negedge aclk);
    end
    repeat (8) @(posedge aclk);
    check_done_count(done_cnt - base_done, 1);
    $display("Test %0d: addr %h, %0d bytes, %0d beats, %0d bursts: %s", idx,
             test_addr[idx], test_size[idx], n, exp_bursts,
             (errors == base_err) ? "pass" : "FAIL");
  endtask

  initial begin : main
    repeat (5) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    check_level("ar_valid", ar_valid, 1'b0);
    check_level("s_valid", s_valid, 1'b0);
    check_level("ctrl_done", ctrl_done, 1'b0);
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    $display("Tests run: %0d, checks failed: %0d", NTESTS, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Budget of 4 cycles per beat plus 200 per test
  initial begin : watchdog
    int limit;
    limit = 5 + 200 * NTESTS;
    for (int t = 0; t < NTESTS; t++) begin
      limit += 4 * ref_beats(test_size[t]);
    end
    repeat (limit) @(posedge aclk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Errors found");
    $finish;
  end

endmodule : tb_rm_top

/* logic/rm_addr_issue.sv */
// Read address channel stage
// Issues the bursts of a command, stepping the address and honouring the credit

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_addr_issue
  import rm_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  logic    cmd_load,
  input  rm_cmd_t cmd,
  input  logic    ar_ready,
  input  logic    burst_drained,
  output logic    ar_valid,
  output rm_ar_t  ar
);

  localparam int AW = `RM_ADDR_WIDTH;
  localparam int BW = `RM_BURST_CNT_WIDTH;
  localparam int CW = `RM_CREDIT_WIDTH;
  localparam logic [AW-1:0] BURST_STEP = AW'(`RM_BURST_BYTES);
  localparam logic [CW-1:0] CREDIT_MAX = CW'(`RM_MAX_OUTSTANDING);
  localparam logic [7:0]    FULL_LEN   = 8'(`RM_BURST_BEATS - 1);

  addr_state_t   state;
  addr_state_t   state_nxt;
  // Bursts still to issue after the current one
  logic [BW-1:0] bursts_to_go;
  logic [AW-1:0] addr_q;
  // Free slots, one per burst the FIFO can still take
  logic [CW-1:0] credit;
  logic          ar_xfer;
  logic          credit_free;
  logic          last_burst;

  assign ar_xfer     = ar_valid & ar_ready;
  assign credit_free = (credit != '0);
  assign last_burst  = (bursts_to_go == '0);

  // Valid and payload come from registers only
  assign ar_valid = (state == AR_ISSUE);
  assign ar.addr  = addr_q;
  assign ar.len   = last_burst ? cmd.final_len : FULL_LEN;

  ////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      AR_IDLE: begin
        if (cmd_load) begin
          state_nxt = credit_free ? AR_ISSUE : AR_WAIT_CREDIT;
        end
      end
      AR_ISSUE: begin
        // After each accept valid drops for a cycle
        if (ar_xfer) begin
          state_nxt = last_burst ? AR_IDLE : AR_WAIT_CREDIT;
        end
      end
      AR_WAIT_CREDIT: begin
        if (credit_free) begin
          state_nxt = AR_ISSUE;
        end
      end
      default: state_nxt = AR_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      state        <= AR_IDLE;
      bursts_to_go <= '0;
    end else begin
      state <= state_nxt;
      if (cmd_load) begin
        bursts_to_go <= cmd.last_burst_idx;
      end else if (ar_xfer && !last_burst) begin
        bursts_to_go <= bursts_to_go - 1'b1;
      end
    end
  end

  // Burst address
  always_ff @(posedge aclk) begin
    if (cmd_load) begin
      addr_q <= cmd.base_addr;
    end else if (ar_xfer) begin
      addr_q <= addr_q + BURST_STEP;
    end
  end

  ////////////////////////////////////////
  // Outstanding credit
  ////////////////////////////////////////

  // Taken on accept, given back when a burst leaves the FIFO
  always_ff @(posedge aclk) begin
    if (areset) begin
      credit <= CREDIT_MAX;
    end else begin
      case ({ar_xfer, burst_drained})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
    end
  end

endmodule : rm_addr_issue

/* logic/rm_beat_fifo.sv */
// Beat buffer between the read data channel and the stream port
// First-word-fall-through FIFO sized to hold every burst in flight

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_beat_fifo
  import rm_pkg::*;
(
  input  logic     aclk,
  input  logic     areset,
  input  logic     r_valid,
  input  rm_beat_t r,
  input  logic     s_ready,
  output logic     r_ready,
  output logic     s_valid,
  output rm_beat_t s_beat,
  output logic     burst_drained
);

  localparam int DEPTH = `RM_FIFO_DEPTH;
  localparam int IW    = $clog2(DEPTH);

  // Storage
  rm_beat_t      mem [DEPTH];
  // Pointers carry one extra wrap bit
  logic [IW:0]   wr_ptr;
  logic [IW:0]   rd_ptr;
  logic          wr_en;
  logic          rd_en;
  logic          empty;

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  // Credit keeps the FIFO from filling, so the bus never stalls
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_ready <= 1'b0;
    end else begin
      r_ready <= 1'b1;
    end
  end

  assign wr_en = r_valid & r_ready;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[IW-1:0]] <= r;
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Head entry is shown as soon as it is written
  assign empty   = (wr_ptr == rd_ptr);
  assign s_valid = ~empty;
  assign s_beat  = mem[rd_ptr[IW-1:0]];
  assign rd_en   = s_valid & s_ready;

  // End of a burst leaving on the stream frees one credit
  assign burst_drained = rd_en & s_beat.last;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule : rm_beat_fifo

/* logic/rm_cfg.svh */
// Read master configuration
// Bus widths, burst shape, outstanding limit and the sizes derived from them

`ifndef RM_CFG_SVH
`define RM_CFG_SVH

////////////////////////////////////////
// Base values
////////////////////////////////////////

// Address width of the read address channel
`define RM_ADDR_WIDTH 32
// Data width of one beat in bits, at least 16
`define RM_DATA_WIDTH 32
// Width of the byte count on the control port
`define RM_SIZE_WIDTH 24
// Beats in a full burst, power of two from 2 to 256
`define RM_BURST_BEATS 16
// Bursts allowed in flight at once
`define RM_MAX_OUTSTANDING 4

////////////////////////////////////////
// Derived values
////////////////////////////////////////

`define RM_DATA_BYTES ((`RM_DATA_WIDTH) / 8)
`define RM_LOG_DATA_BYTES ($clog2(`RM_DATA_BYTES))
`define RM_BURST_BYTES ((`RM_BURST_BEATS) * (`RM_DATA_BYTES))
`define RM_LOG_BURST ($clog2(`RM_BURST_BEATS))
// Beat count minus one, as held after rounding
`define RM_BEAT_CNT_WIDTH ((`RM_SIZE_WIDTH) - (`RM_LOG_DATA_BYTES))
// Burst count minus one
`define RM_BURST_CNT_WIDTH ((`RM_BEAT_CNT_WIDTH) - (`RM_LOG_BURST))
`define RM_CREDIT_WIDTH ($clog2((`RM_MAX_OUTSTANDING) + 1))
// Room for every burst in flight, kept a power of two
`define RM_FIFO_DEPTH (1 << $clog2((`RM_BURST_BEATS) * (`RM_MAX_OUTSTANDING)))

`endif

/* logic/rm_completion.sv */
// Transfer completion tracking
// Counts finished bursts on the read data channel and pulses done after the final one

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_completion
  import rm_pkg::*;
(
  input  logic    aclk,
  input  logic    areset,
  input  logic    cmd_load,
  input  rm_cmd_t cmd,
  input  logic    r_valid,
  input  logic    r_ready,
  input  logic    r_last,
  output logic    ctrl_done
);

  localparam int BW = `RM_BURST_CNT_WIDTH;

  // Bursts still expected after the current one
  logic [BW-1:0] bursts_left;
  // A transfer is running
  logic          active;
  logic          last_xfer;
  logic          final_burst;

  assign last_xfer   = r_valid & r_ready & r_last;
  assign final_burst = (bursts_left == '0);

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
      active      <= 1'b0;
      ctrl_done   <= 1'b0;
    end else begin
      // Single cycle pulse after the last beat of the last burst
      ctrl_done <= active & last_xfer & final_burst;
      if (cmd_load) begin
        bursts_left <= cmd.last_burst_idx;
        active      <= 1'b1;
      end else if (active && last_xfer) begin
        if (final_burst) begin
          active <= 1'b0;
        end else begin
          bursts_left <= bursts_left - 1'b1;
        end
      end
    end
  end

endmodule : rm_completion

/* logic/rm_pkg.sv */
// Read master types
// Command, address channel, beat payload and address FSM states

`include "rm_cfg.svh"

package rm_pkg;

  ////////////////////////////////////////
  // Transfer command
  ////////////////////////////////////////

  // Built once per start and held until the next one
  typedef struct packed {
    // Start address aligned down to a burst
    logic [`RM_ADDR_WIDTH-1:0]      base_addr;
    // Number of bursts minus one
    logic [`RM_BURST_CNT_WIDTH-1:0] last_burst_idx;
    // Beats minus one in the last burst
    logic [7:0]                     final_len;
  } rm_cmd_t;

  ////////////////////////////////////////
  // Bus payloads
  ////////////////////////////////////////

  // Read address channel payload, AXI style len
  typedef struct packed {
    logic [`RM_ADDR_WIDTH-1:0] addr;
    logic [7:0]                len;
  } rm_ar_t;

  // One data beat, used on the read data channel and the stream
  typedef struct packed {
    logic [`RM_DATA_WIDTH-1:0] data;
    logic                      last;
  } rm_beat_t;

  // Address issue FSM
  typedef enum logic [1:0] {
    AR_IDLE,
    AR_ISSUE,
    AR_WAIT_CREDIT
  } addr_state_t;

endpackage : rm_pkg

/* logic/rm_read_master.sv */
// Memory read master with stream output
// Splits a byte request into bursts, buffers the beats and streams them out

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_read_master
  import rm_pkg::*;
(
  input  logic                      aclk,
  input  logic                      areset,
  // Control port
  input  logic                      ctrl_start,
  input  logic [`RM_ADDR_WIDTH-1:0] ctrl_addr,
  input  logic [`RM_SIZE_WIDTH-1:0] ctrl_size_bytes,
  output logic                      ctrl_done,
  // Read address channel
  output logic                      ar_valid,
  input  logic                      ar_ready,
  output rm_ar_t                    ar,
  // Read data channel
  input  logic                      r_valid,
  output logic                      r_ready,
  input  rm_beat_t                  r,
  // Stream output
  output logic                      s_valid,
  input  logic                      s_ready,
  output rm_beat_t                  s_beat
);

  rm_cmd_t cmd;
  logic    cmd_load;
  logic    burst_drained;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  rm_request_setup u_request_setup (
    .aclk            (aclk),
    .areset          (areset),
    .ctrl_start      (ctrl_start),
    .ctrl_addr       (ctrl_addr),
    .ctrl_size_bytes (ctrl_size_bytes),
    .cmd_load        (cmd_load),
    .cmd             (cmd)
  );

  rm_addr_issue u_addr_issue (
    .aclk          (aclk),
    .areset        (areset),
    .cmd_load      (cmd_load),
    .cmd           (cmd),
    .ar_ready      (ar_ready),
    .burst_drained (burst_drained),
    .ar_valid      (ar_valid),
    .ar            (ar)
  );

  // Returns a credit to the address stage per drained burst
  rm_beat_fifo u_beat_fifo (
    .aclk          (aclk),
    .areset        (areset),
    .r_valid       (r_valid),
    .r             (r),
    .s_ready       (s_ready),
    .r_ready       (r_ready),
    .s_valid       (s_valid),
    .s_beat        (s_beat),
    .burst_drained (burst_drained)
  );

  rm_completion u_completion (
    .aclk      (aclk),
    .areset    (areset),
    .cmd_load  (cmd_load),
    .cmd       (cmd),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r_last    (r.last),
    .ctrl_done (ctrl_done)
  );

endmodule : rm_read_master

/* logic/rm_request_setup.sv */
// Request setup for the read master
// Samples a start, rounds the size to beats, aligns the address, builds the command

`timescale 1ns/100ps
`include "rm_cfg.svh"

module rm_request_setup
  import rm_pkg::*;
(
  input  logic                      aclk,
  input  logic                      areset,
  input  logic                      ctrl_start,
  input  logic [`RM_ADDR_WIDTH-1:0] ctrl_addr,
  input  logic [`RM_SIZE_WIDTH-1:0] ctrl_size_bytes,
  output logic                      cmd_load,
  output rm_cmd_t                   cmd
);

  localparam int AW  = `RM_ADDR_WIDTH;
  localparam int SW  = `RM_SIZE_WIDTH;
  localparam int LDB = `RM_LOG_DATA_BYTES;
  localparam int TW  = `RM_BEAT_CNT_WIDTH;
  localparam int LB  = `RM_LOG_BURST;
  // Low address bits inside one full burst
  localparam logic [AW-1:0] BURST_MASK = AW'(`RM_BURST_BYTES - 1);

  logic          start_d1;
  // Whole beats in the request, before the minus one
  logic [TW-1:0] size_beats;
  // Size has a partial beat at the end
  logic          partial_beat;
  // Beats minus one
  logic [TW-1:0] total_len_r;
  logic [AW-1:0] addr_r;

  assign size_beats   = ctrl_size_bytes[SW-1:LDB];
  assign partial_beat = (ctrl_size_bytes[LDB-1:0] != '0);

  ////////////////////////////////////////
  // Start delay line
  ////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      cmd_load <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      cmd_load <= start_d1;
    end
  end

  // First step on the start edge
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // A partial beat rounds up, which cancels the minus one
      total_len_r <= partial_beat ? size_beats : size_beats - 1'b1;
      addr_r      <= ctrl_addr & ~BURST_MASK;
    end
  end

  // Second step splits the beat count into bursts
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      cmd.base_addr      <= addr_r;
      cmd.last_burst_idx <= total_len_r[TW-1:LB];
      cmd.final_len      <= 8'(total_len_r[LB-1:0]);
    end
  end

endmodule : rm_request_setup
